/* design/glcm_pkg.sv */
// GLCM core types: pixel, count, direction, distance, matrix index and control states
package glcm_pkg;

	// ------------------------------------------------------------
	// Data types
	// ------------------------------------------------------------
	typedef logic [4:0] pixel_t;
	typedef logic [7:0] count_t;
	typedef logic [1:0] dir_t;
	typedef logic [3:0] dist_t;

	// Matrix entry index, reference level in the upper half
	typedef logic [9:0] pair_idx_t;

	localparam int GRAY_LEVELS  = 32;
	// 1024 byte counts, four per 32-bit word
	localparam int MATRIX_WORDS = 256;

	// ------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,
		LOAD_REQ,
		LOAD_DATA,
		ACCUM,
		STORE_REQ,
		STORE_DATA,
		STORE_RESP,
		DONE
	} ctrl_state_t;

endpackage

/* design/dram_pkg.sv */
// Memory side types: byte address, data beat and burst geometry
package dram_pkg;

	typedef logic [31:0] addr_t;
	// Four bytes per beat, byte 0 in the low lane
	typedef logic [31:0] word_t;

	localparam int PIX_PER_WORD = 4;

	// ------------------------------------------------------------
	// Fixed burst shape
	// ------------------------------------------------------------
	localparam int BURST_BEATS = 16;
	localparam int BURST_BYTES = 64;

	typedef logic [3:0] beat_idx_t;
	// Wide enough for the 16 store bursts
	typedef logic [5:0] burst_idx_t;

endpackage

/* design/glcm_ctrl.sv */
// GLCM control FSM sequencing image load, pair accumulation and matrix store
`timescale 1ns/1ps

module glcm_ctrl
	import glcm_pkg::*;
#(
	parameter int IMG_SIDE = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic ar_done,
	input  logic aw_done,
	input  logic rvalid,
	input  logic rlast,
	input  logic wready,
	input  logic bvalid,
	input  logic pixel_last,
	input  logic beat_last,
	input  logic burst_last,
	output logic ar_req,
	output logic aw_req,
	output logic load_en,
	output logic acc_en,
	output logic storing,
	output logic wvalid,
	output logic cnt_clear,
	output logic beat_step,
	output logic burst_step,
	output logic out_valid
);

	localparam int SCAN_CYCLES = IMG_SIDE * IMG_SIDE;

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (in_valid) begin
					state_nxt = LOAD_REQ;
				end
			end
			LOAD_REQ: begin
				if (ar_done) begin
					state_nxt = LOAD_DATA;
				end
			end
			LOAD_DATA: begin
				if (rvalid && rlast) begin
					state_nxt = burst_last ? ACCUM : LOAD_REQ;
				end
			end
			// One reference pixel per cycle
			ACCUM: begin
				if (pixel_last) begin
					state_nxt = STORE_REQ;
				end
			end
			STORE_REQ: begin
				if (aw_done) begin
					state_nxt = STORE_DATA;
				end
			end
			STORE_DATA: begin
				if (wready && beat_last) begin
					state_nxt = STORE_RESP;
				end
			end
			STORE_RESP: begin
				if (bvalid) begin
					state_nxt = burst_last ? DONE : STORE_REQ;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	assign ar_req  = (state == LOAD_REQ);
	assign aw_req  = (state == STORE_REQ);
	assign load_en = (state == LOAD_DATA);
	assign acc_en  = (state == ACCUM);
	assign storing = state inside {STORE_REQ, STORE_DATA, STORE_RESP};
	assign wvalid  = (state == STORE_DATA);

	// Counters restart on start and again between scan and store
	assign cnt_clear  = (state == IDLE && in_valid) || (acc_en && pixel_last);
	assign beat_step  = (load_en && rvalid) || (wvalid && wready);
	assign burst_step = (load_en && rvalid && rlast) || (state == STORE_RESP && bvalid);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= (state == DONE);
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid);

	// Each write burst opens on beat 0 once its address is taken
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(wvalid) |-> !aw_done && !beat_last);

	// Scan length set by the pixel counter's last flag
	assert property (@(posedge clk) disable iff (!rst_n)
		$fell(acc_en) |-> $past(acc_en, SCAN_CYCLES) && !$past(acc_en, SCAN_CYCLES + 1));

endmodule

/* design/glcm_counter.sv */
// Pixel, beat and burst counters with their last flags
`timescale 1ns/1ps

module glcm_counter
	import glcm_pkg::*, dram_pkg::*;
#(
	parameter int IMG_SIDE = 8,
	localparam int PIX_W = $clog2(IMG_SIDE * IMG_SIDE)
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cnt_clear,
	input  logic             acc_en,
	input  logic             beat_step,
	input  logic             burst_step,
	input  logic             storing,
	output logic [PIX_W-1:0] pixel_idx,
	output beat_idx_t        beat_idx,
	output burst_idx_t       burst_idx,
	output logic             pixel_last,
	output logic             beat_last,
	output logic             burst_last
);

	localparam int IMG_BURSTS   = IMG_SIDE * IMG_SIDE / BURST_BYTES;
	localparam int STORE_BURSTS = MATRIX_WORDS / BURST_BEATS;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pixel_idx <= '0;
			beat_idx  <= '0;
			burst_idx <= '0;
		end else if (cnt_clear) begin
			pixel_idx <= '0;
			beat_idx  <= '0;
			burst_idx <= '0;
		end else begin
			if (acc_en) begin
				pixel_idx <= pixel_idx + 1'b1;
			end
			// Beat count wraps on its own after 16 beats
			if (beat_step) begin
				beat_idx <= beat_idx + 1'b1;
			end
			if (burst_step) begin
				burst_idx <= burst_idx + 1'b1;
			end
		end
	end

	assign pixel_last = (pixel_idx == PIX_W'(IMG_SIDE * IMG_SIDE - 1));
	assign beat_last  = (beat_idx == beat_idx_t'(BURST_BEATS - 1));
	assign burst_last = storing ? (burst_idx == burst_idx_t'(STORE_BURSTS - 1))
		: (burst_idx == burst_idx_t'(IMG_BURSTS - 1));

endmodule

/* design/glcm_dram_port.sv */
// AXI read and write address channels with latched base addresses
`timescale 1ns/1ps

module glcm_dram_port
	import dram_pkg::*;
#(
	parameter int IMG_SIDE = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  addr_t      in_addr_m,
	input  addr_t      in_addr_g,
	input  logic       ar_req,
	input  logic       aw_req,
	input  burst_idx_t burst_idx,
	input  logic       arready,
	input  logic       awready,
	output addr_t      araddr,
	output logic       arvalid,
	output addr_t      awaddr,
	output logic       awvalid,
	output logic       ar_done,
	output logic       aw_done
);

	addr_t m_base;
	addr_t g_base;
	addr_t burst_off;

	always_ff @(posedge clk) begin
		if (in_valid) begin
			m_base <= in_addr_m;
			g_base <= in_addr_g;
		end
	end

	assign burst_off = addr_t'(burst_idx) * addr_t'(BURST_BYTES);

	// Address captured once per request, then held until ready
	always_ff @(posedge clk) begin
		if (ar_req && !arvalid) begin
			araddr <= m_base + burst_off;
		end
		if (aw_req && !awvalid) begin
			awaddr <= g_base + burst_off;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
		end else begin
			if (ar_done) begin
				arvalid <= 1'b0;
			end else if (ar_req) begin
				arvalid <= 1'b1;
			end
			if (aw_done) begin
				awvalid <= 1'b0;
			end else if (aw_req) begin
				awvalid <= 1'b1;
			end
		end
	end

	assign ar_done = arvalid && arready;
	assign aw_done = awvalid && awready;

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr));
	assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr));

	// Reads stay inside the image
	assert property (@(posedge clk) disable iff (!rst_n)
		arvalid |-> araddr - m_base < addr_t'(IMG_SIDE * IMG_SIDE));

endmodule

/* design/glcm_image_buf.sv */
// Image storage, beat unpacking and reference/neighbour pixel lookup
`timescale 1ns/1ps

module glcm_image_buf
	import glcm_pkg::*, dram_pkg::*;
#(
	parameter int IMG_SIDE = 8,
	localparam int PIX_W = $clog2(IMG_SIDE * IMG_SIDE)
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  dir_t             in_dir,
	input  dist_t            in_dis,
	input  logic             load_en,
	input  logic             rvalid,
	input  word_t            rdata,
	input  burst_idx_t       burst_idx,
	input  beat_idx_t        beat_idx,
	input  logic [PIX_W-1:0] pixel_idx,
	output pixel_t           ref_pixel,
	output pixel_t           nbr_pixel,
	output logic             pair_valid
);

	localparam int SIDE_W = $clog2(IMG_SIDE);
	// One spare bit so row plus offset never wraps
	localparam int OFF_W  = $bits(dist_t) + 1;

	pixel_t img [IMG_SIDE * IMG_SIDE];

	dir_t  dir_q;
	dist_t dis_q;
	dist_t row_off;
	dist_t col_off;

	logic [PIX_W-1:0] wr_base;
	logic [PIX_W-1:0] nbr_idx;
	logic [OFF_W-1:0] nbr_row;
	logic [OFF_W-1:0] nbr_col;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dir_q <= '0;
			dis_q <= '0;
		end else if (in_valid) begin
			dir_q <= in_dir;
			dis_q <= in_dis;
		end
	end

	// ------------------------------------------------------------
	// Load, four pixels per beat
	// ------------------------------------------------------------
	assign wr_base = PIX_W'({burst_idx, beat_idx} * PIX_PER_WORD);

	always_ff @(posedge clk) begin
		if (load_en && rvalid) begin
			for (int j = 0; j < PIX_PER_WORD; j++) begin
				img[wr_base + PIX_W'(j)] <= rdata[8*j +: $bits(pixel_t)];
			end
		end
	end

	// ------------------------------------------------------------
	// Neighbour offset
	// ------------------------------------------------------------
	always_comb begin
		case (dir_q)
			2'd1: begin
				row_off = dis_q;
				col_off = '0;
			end
			2'd2: begin
				row_off = '0;
				col_off = dis_q;
			end
			// Both diagonal codes
			default: begin
				row_off = dis_q;
				col_off = dis_q;
			end
		endcase
	end

	assign nbr_row = OFF_W'(pixel_idx[PIX_W-1:SIDE_W]) + OFF_W'(row_off);
	assign nbr_col = OFF_W'(pixel_idx[SIDE_W-1:0]) + OFF_W'(col_off);

	assign pair_valid = (nbr_row < OFF_W'(IMG_SIDE)) && (nbr_col < OFF_W'(IMG_SIDE));
	assign nbr_idx    = {nbr_row[SIDE_W-1:0], nbr_col[SIDE_W-1:0]};

	assign ref_pixel = img[pixel_idx];
	assign nbr_pixel = img[nbr_idx];

endmodule

/* design/glcm_hist.sv */
// Co-occurrence count matrix with increment, clear on start and word readout
`timescale 1ns/1ps

module glcm_hist
	import glcm_pkg::*, dram_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic       acc_en,
	input  pixel_t     ref_pixel,
	input  pixel_t     nbr_pixel,
	input  logic       pair_valid,
	input  burst_idx_t burst_idx,
	input  beat_idx_t  beat_idx,
	output word_t      wdata
);

	localparam int WORD_W = $clog2(MATRIX_WORDS);
	localparam int LANE_W = $clog2(PIX_PER_WORD);

	count_t mat [GRAY_LEVELS * GRAY_LEVELS];

	pair_idx_t         inc_idx;
	logic [WORD_W-1:0] word_idx;

	assign inc_idx = {ref_pixel, nbr_pixel};

	// Counts wrap at 256
	always_ff @(posedge clk) begin
		if (in_valid) begin
			for (int i = 0; i < GRAY_LEVELS * GRAY_LEVELS; i++) begin
				mat[i] <= '0;
			end
		end else if (acc_en && pair_valid) begin
			mat[inc_idx] <= mat[inc_idx] + 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Store readout
	// ------------------------------------------------------------
	assign word_idx = WORD_W'({burst_idx, beat_idx});

	always_comb begin
		for (int j = 0; j < PIX_PER_WORD; j++) begin
			wdata[8*j +: $bits(count_t)] = mat[pair_idx_t'({word_idx, LANE_W'(j)})];
		end
	end

	// Clear and accumulate never overlap
	assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> !acc_en);

endmodule

/* design/glcm_top.sv */
// GLCM engine top level connecting control, counters, AXI port, image buffer and matrix
`timescale 1ns/1ps

module glcm_top
	import glcm_pkg::*, dram_pkg::*;
#(
	parameter int IMG_SIDE = 8,
	localparam int PIX_W = $clog2(IMG_SIDE * IMG_SIDE)
) (
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t in_addr_m,
	input  addr_t in_addr_g,
	input  dir_t  in_dir,
	input  dist_t in_dis,
	input  logic  in_valid,
	output logic  out_valid,
	// AXI read
	output addr_t araddr,
	output logic  arvalid,
	input  logic  arready,
	input  word_t rdata,
	input  logic  rvalid,
	input  logic  rlast,
	// AXI write
	output addr_t awaddr,
	output logic  awvalid,
	input  logic  awready,
	output word_t wdata,
	output logic  wvalid,
	output logic  wlast,
	input  logic  wready,
	input  logic  bvalid
);

	logic ar_req;
	logic aw_req;
	logic ar_done;
	logic aw_done;
	logic load_en;
	logic acc_en;
	logic storing;
	logic cnt_clear;
	logic beat_step;
	logic burst_step;
	logic pixel_last;
	logic burst_last;

	logic [PIX_W-1:0] pixel_idx;
	beat_idx_t        beat_idx;
	burst_idx_t       burst_idx;
	pixel_t           ref_pixel;
	pixel_t           nbr_pixel;
	logic             pair_valid;

	// Beat 15 of a store burst doubles as wlast
	glcm_ctrl #(.IMG_SIDE(IMG_SIDE)) glcm_ctrl_inst (.beat_last(wlast), .*);

	glcm_counter #(.IMG_SIDE(IMG_SIDE)) glcm_counter_inst (.beat_last(wlast), .*);

	glcm_dram_port #(.IMG_SIDE(IMG_SIDE)) glcm_dram_port_inst (.*);

	glcm_image_buf #(.IMG_SIDE(IMG_SIDE)) glcm_image_buf_inst (.*);

	glcm_hist glcm_hist_inst (.*);

endmodule

/* tb/glcm_tb.sv */
// GLCM testbench: AXI memory model, reference GLCM model, result checks and watchdog
`timescale 1ns/1ps

module glcm_tb
	import glcm_pkg::*, dram_pkg::*;
();

	localparam int IMG_SIDE     = 8;
	localparam int IMG_PIX      = IMG_SIDE * IMG_SIDE;
	localparam int IMG_WORDS    = IMG_PIX / PIX_PER_WORD;
	localparam int IMG_BURSTS   = IMG_PIX / BURST_BYTES;
	localparam int STORE_BURSTS = MATRIX_WORDS / BURST_BEATS;
	localparam int ENTRIES      = GRAY_LEVELS * GRAY_LEVELS;
	localparam int CLK_PERIOD   = 100;
	// Generous cycle bound for one load, scan and store
	localparam int TEST_BOUND   = 3000;

	logic  clk;
	logic  rst_n;
	addr_t in_addr_m;
	addr_t in_addr_g;
	dir_t  in_dir;
	dist_t in_dis;
	logic  in_valid;
	logic  out_valid;
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	word_t rdata;
	logic  rvalid;
	logic  rlast;
	addr_t awaddr;
	logic  awvalid;
	logic  awready;
	word_t wdata;
	logic  wvalid;
	logic  wlast;
	logic  wready;
	logic  bvalid;

	// Memory model state
	word_t img_mem [addr_t];
	word_t res_mem [addr_t];
	addr_t rd_q [$];
	addr_t wr_q [$];
	int    rd_beat = 0;
	int    wr_beat = 0;
	int    b_pend = 0;
	int    ar_count = 0;
	int    aw_count = 0;
	int    b_count = 0;
	int    ov_count = 0;
	int    ar_base = 0;
	int    aw_base = 0;
	int    b_base = 0;
	int    ov_base = 0;
	addr_t cur_m = '0;
	addr_t cur_g = '0;
	logic  stall_en = 1'b0;
	int    cur_test = 0;
	int    err_count = 0;
	int    n_tests = 0;

	// Test list from the stimulus file
	addr_t st_m [$];
	addr_t st_g [$];
	dir_t  st_dir [$];
	dist_t st_dis [$];
	int    st_total [$];

	count_t exp_mat [ENTRIES];
	count_t got_mat [ENTRIES];
	count_t diag_mat [ENTRIES];
	logic   diag_saved = 1'b0;
	addr_t  diag_m = '0;
	dist_t  diag_dis = '0;

	glcm_top #(.IMG_SIDE(IMG_SIDE)) glcm_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_addr_m (in_addr_m),
		.in_addr_g (in_addr_g),
		.in_dir    (in_dir),
		.in_dis    (in_dis),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rvalid    (rvalid),
		.rlast     (rlast),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wvalid    (wvalid),
		.wlast     (wlast),
		.wready    (wready),
		.bvalid    (bvalid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		err_count++;
		$display("** Error: %s = %h, expected %h (test %0d)", name, got, exp, cur_test);
	endtask

	task automatic report_event(input string msg);
		err_count++;
		$display("Error: %s (test %0d)", msg, cur_test);
	endtask

	function automatic logic draw_ready();
		if (!stall_en) begin
			return 1'b1;
		end
		return ($urandom % 4) != 0;
	endfunction

	function automatic pixel_t image_pixel(input addr_t base, input int k);
		word_t w;
		w = img_mem[base + addr_t'((k / PIX_PER_WORD) * PIX_PER_WORD)];
		return w[8 * (k % PIX_PER_WORD) +: 5];
	endfunction

	// ------------------------------------------------------------
	// AXI memory model, sampling side
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (rst_n) begin
			if (arvalid && arready) begin
				if (araddr != cur_m + addr_t'((ar_count - ar_base) * BURST_BYTES)) begin
					report_mismatch("araddr", araddr,
						cur_m + addr_t'((ar_count - ar_base) * BURST_BYTES));
				end
				rd_q.push_back(araddr);
				ar_count++;
			end
			if (rvalid) begin
				if (rd_beat == BURST_BEATS - 1) begin
					rd_beat = 0;
					void'(rd_q.pop_front());
				end else begin
					rd_beat++;
				end
			end
			if (awvalid && awready) begin
				if (awaddr != cur_g + addr_t'((aw_count - aw_base) * BURST_BYTES)) begin
					report_mismatch("awaddr", awaddr,
						cur_g + addr_t'((aw_count - aw_base) * BURST_BYTES));
				end
				wr_q.push_back(awaddr);
				aw_count++;
			end
			if (wvalid && wready) begin
				if (wr_q.size() == 0) begin
					report_event("write data beat arrived without a write address");
				end else begin
					res_mem[wr_q[0] + addr_t'(wr_beat * 4)] = wdata;
					if (wlast != (wr_beat == BURST_BEATS - 1)) begin
						report_mismatch("wlast", 32'(wlast), 32'(wr_beat == BURST_BEATS - 1));
					end
					if (wr_beat == BURST_BEATS - 1) begin
						wr_beat = 0;
						void'(wr_q.pop_front());
						b_pend++;
					end else begin
						wr_beat++;
					end
				end
			end
			if (bvalid) begin
				b_pend--;
				b_count++;
			end
			if (out_valid) begin
				ov_count++;
				if (b_count - b_base != STORE_BURSTS) begin
					report_event("out_valid came before the last write response");
				end
			end
		end
	end

	// Driving side, random ready and rvalid gaps when stalls are on
	initial begin
		arready = 1'b0;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = '0;
		forever begin
			@(negedge clk);
			arready = draw_ready();
			awready = draw_ready();
			wready  = draw_ready();
			bvalid  = (b_pend > 0) && draw_ready();
			if (rd_q.size() != 0 && draw_ready()) begin
				rvalid = 1'b1;
				rlast  = (rd_beat == BURST_BEATS - 1);
				rdata  = img_mem.exists(rd_q[0] + addr_t'(rd_beat * 4)) ?
					img_mem[rd_q[0] + addr_t'(rd_beat * 4)] : '0;
			end else begin
				rvalid = 1'b0;
				rlast  = 1'b0;
				rdata  = '0;
			end
		end
	end

	// ------------------------------------------------------------
	// Reference model and result checks
	// ------------------------------------------------------------
	task automatic build_expected(input addr_t m, input dir_t dir, input dist_t dis);
		int roff;
		int coff;
		int r2;
		int c2;
		pixel_t a;
		pixel_t b;
		roff = (dir == 2'd2) ? 0 : int'(dis);
		coff = (dir == 2'd1) ? 0 : int'(dis);
		for (int i = 0; i < ENTRIES; i++) begin
			exp_mat[i] = '0;
		end
		for (int r = 0; r < IMG_SIDE; r++) begin
			for (int c = 0; c < IMG_SIDE; c++) begin
				r2 = r + roff;
				c2 = c + coff;
				if (r2 < IMG_SIDE && c2 < IMG_SIDE) begin
					a = image_pixel(m, r * IMG_SIDE + c);
					b = image_pixel(m, r2 * IMG_SIDE + c2);
					exp_mat[int'(a) * GRAY_LEVELS + int'(b)] += 8'd1;
				end
			end
		end
	endtask

	task automatic check_result(input int t);
		word_t w;
		addr_t a;
		int    total;
		total = 0;
		for (int i = 0; i < MATRIX_WORDS; i++) begin
			a = st_g[t] + addr_t'(i * 4);
			w = '0;
			if (!res_mem.exists(a)) begin
				report_event($sformatf("no matrix word written at address %h", a));
			end else begin
				w = res_mem[a];
			end
			for (int j = 0; j < PIX_PER_WORD; j++) begin
				got_mat[i * 4 + j] = w[8 * j +: 8];
				total += int'(got_mat[i * 4 + j]);
				if (got_mat[i * 4 + j] != exp_mat[i * 4 + j]) begin
					report_mismatch($sformatf("wdata count[%0d]", i * 4 + j),
						32'(got_mat[i * 4 + j]), 32'(exp_mat[i * 4 + j]));
				end
			end
		end
		if (total != st_total[t]) begin
			report_mismatch("pair total", total, st_total[t]);
		end
		if (ar_count - ar_base != IMG_BURSTS) begin
			report_mismatch("read burst count", ar_count - ar_base, IMG_BURSTS);
		end
		// Same image and distance on the other diagonal code
		if (st_dir[t] == 2'd0 || st_dir[t] == 2'd3) begin
			if (diag_saved && diag_m == st_m[t] && diag_dis == st_dis[t]) begin
				for (int i = 0; i < ENTRIES; i++) begin
					if (got_mat[i] != diag_mat[i]) begin
						report_mismatch($sformatf("diagonal count[%0d]", i),
							32'(got_mat[i]), 32'(diag_mat[i]));
					end
				end
			end
			diag_saved = 1'b1;
			diag_m     = st_m[t];
			diag_dis   = st_dis[t];
			diag_mat   = got_mat;
		end
	endtask

	task automatic read_stimulus();
		int          fd;
		string       line;
		logic [31:0] m_v;
		logic [31:0] g_v;
		logic [31:0] dir_v;
		logic [31:0] dis_v;
		logic [31:0] total_v;
		fd = $fopen("tb/glcm_stimulus.txt", "r");
		if (fd == 0) begin
			report_event("cannot open tb/glcm_stimulus.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if ($sscanf(line, "%h %h %h %h %h", m_v, g_v, dir_v, dis_v, total_v) == 5) begin
				st_m.push_back(m_v);
				st_g.push_back(g_v);
				st_dir.push_back(dir_t'(dir_v));
				st_dis.push_back(dist_t'(dis_v));
				st_total.push_back(int'(total_v));
			end
		end
		$fclose(fd);
		n_tests = st_m.size();
		if (n_tests == 0) begin
			report_event("stimulus file holds no tests");
		end
	endtask

	task automatic run_test(input int t);
		cur_test = t;
		cur_m    = st_m[t];
		cur_g    = st_g[t];
		// Later tests run with stalls, back to back
		stall_en = (t >= 4);
		if (!img_mem.exists(cur_m)) begin
			for (int i = 0; i < IMG_WORDS; i++) begin
				img_mem[cur_m + addr_t'(i * 4)] = $urandom;
			end
		end
		res_mem.delete();
		ar_base = ar_count;
		aw_base = aw_count;
		b_base  = b_count;
		ov_base = ov_count;
		build_expected(cur_m, st_dir[t], st_dis[t]);
		in_addr_m = cur_m;
		in_addr_g = cur_g;
		in_dir    = st_dir[t];
		in_dis    = st_dis[t];
		in_valid  = 1'b1;
		@(negedge clk);
		in_valid = 1'b0;
		while (ov_count == ov_base) begin
			@(negedge clk);
		end
		@(negedge clk);
		if (ov_count - ov_base != 1) begin
			report_mismatch("out_valid pulses", ov_count - ov_base, 1);
		end
		check_result(t);
	endtask

	initial begin
		void'($urandom(13));
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_addr_m = '0;
		in_addr_g = '0;
		in_dir    = '0;
		in_dis    = '0;
		read_stimulus();
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (arvalid || awvalid || wvalid || out_valid) begin
			report_event("valid outputs not low after reset");
		end
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("Tests run: %0d, errors: %0d", n_tests, err_count);
		if (err_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog sized from the number of tests
	initial begin
		wait (n_tests > 0);
		#((n_tests * TEST_BOUND + 20) * CLK_PERIOD);
		$display("Error: run did not finish within %0d cycles per test", TEST_BOUND);
		$display("Test failures found");
		$finish;
	end

endmodule

/* tb/glcm_stimulus.txt */
# in_addr_m in_addr_g in_dir in_dis expected_pair_total (all hex)
# Tests 0 to 3 run without stalls, the rest with random stalls
00001000 00010000 1 1 38
00001000 00011000 2 2 30
00002000 00012000 3 1 31
00002000 00013000 0 1 31
00003000 00014000 1 7 08
00002000 00015000 3 1 31
00003000 00016000 3 3 19
00003000 00017000 2 8 00
00001000 00018000 0 0 40

/* tb.f */
design/glcm_pkg.sv
design/dram_pkg.sv
design/glcm_ctrl.sv
design/glcm_counter.sv
design/glcm_dram_port.sv
design/glcm_image_buf.sv
design/glcm_hist.sv
design/glcm_top.sv
tb/glcm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GLCM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module glcm_tb -o Vglcm_tb

# A crashed run counts as a failure
./obj_dir/Vglcm_tb > sim.log 2>&1 || echo "Test failures found" >> sim.log
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation passed"
